//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := sig_scan_tb
FILELIST := sig_scan.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Testbench passed" $(LOG) || (echo "Simulation ended without passing"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dfa_matcher.sv
module dfa_matcher (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [7:0]              char_in,
  input  logic                    char_vld,
  input  logic                    scanning,
  input  sig_scan_pkg::dfa_state_t ctx_state,
  input  logic                    ctx_vld,
  output sig_scan_pkg::dfa_state_t state_out,
  output logic                    accept
);

  import sig_scan_pkg::*;

  // State value that sits one byte short of a full match
  localparam dfa_state_t LAST_STATE = dfa_state_t'(SIG_LEN - 1);

  // Input stage
  logic [7:0] char_r;
  logic       char_vld_r;
  dfa_state_t ctx_state_r;
  logic       ctx_vld_r;

  // DFA state, also the registered state output
  dfa_state_t state_q;

  // Next-state logic
  dfa_state_t base_state;
  dfa_state_t next_state;
  logic       hit;

  // Register everything coming in, bytes outside a packet are dropped here
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      char_vld_r <= 1'b0;
      ctx_vld_r  <= 1'b0;
    end
    else
    begin
      char_vld_r <= char_vld & scanning;
      ctx_vld_r  <= ctx_vld;
    end
  end

  always_ff @(posedge clk)
  begin
    char_r      <= char_in;
    ctx_state_r <= ctx_state;
  end

  // A restored context replaces the running state
  // The first byte may land in the same cycle, so it advances from the restored value
  always_comb
  begin
    base_state = ctx_vld_r ? ctx_state_r : state_q;
    next_state = base_state;
    hit        = 1'b0;
    if (char_vld_r)
    begin
      if (char_r == SIG_BYTES[base_state])
      begin
        if (base_state == LAST_STATE)
        begin
          // Full signature seen, start over
          next_state = '0;
          hit        = 1'b1;
        end
        else
        begin
          next_state = base_state + dfa_state_t'(1);
        end
      end
      else if (char_r == SIG_BYTES[0])
      begin
        // 'H' only occurs at the head, so a mismatch on it restarts at one
        next_state = dfa_state_t'(1);
      end
      else
      begin
        next_state = '0;
      end
    end
  end

  // Output stage
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q <= '0;
      accept  <= 1'b0;
    end
    else
    begin
      state_q <= next_state;
      accept  <= hit;
    end
  end

  assign state_out = state_q;

endmodule

//--- match_counter.sv
module match_counter #(
  parameter int COUNT_W = 16
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               accept,
  input  logic               clr,
  input  logic               commit,
  input  logic               discard,
  output logic               fired,
  output logic [COUNT_W-1:0] count
);

  // Fired flag as seen at commit
  // An accept in the commit cycle still counts
  logic fired_now;

  assign fired_now = fired | accept;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      fired <= 1'b0;
      count <= '0;
    end
    else
    begin
      // Speculative flag for the current packet
      if (clr || discard)
      begin
        fired <= 1'b0;
      end
      else if (accept)
      begin
        fired <= 1'b1;
      end
      // At most one hit per packet, wraps at full width
      if (commit)
      begin
        count <= count + COUNT_W'(fired_now);
      end
    end
  end

endmodule

//--- scan_control_fsm.sv
module scan_control_fsm #(
  parameter int STREAMS = 64
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       pkt_start,
  input  logic                       eop,
  input  logic                       enable,
  input  logic                       new_stream,
  input  logic [$clog2(STREAMS)-1:0] stream_id,
  output logic                       ready,
  output logic                       ld,
  output logic                       sv,
  output logic                       clr,
  output logic                       commit,
  output logic                       discard,
  output logic                       scanning,
  output logic [$clog2(STREAMS)-1:0] stream_idx,
  output logic                       new_stream_q
);

  import sig_scan_pkg::*;

  // Wide enough to count MATCHER_LAT drain cycles
  localparam int DRAIN_W = $clog2(MATCHER_LAT + 1);

  ctrl_state_t        state;
  logic [DRAIN_W-1:0] drain_cnt;
  logic               enable_q;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state     <= IDLE;
      drain_cnt <= '0;
    end
    else
    begin
      case (state)
        IDLE:
        begin
          if (pkt_start)
          begin
            state <= LOAD;
          end
        end
        // One cycle to fetch the stream context
        LOAD:
        begin
          state <= SCAN;
        end
        SCAN:
        begin
          if (eop)
          begin
            state     <= DRAIN;
            drain_cnt <= '0;
          end
        end
        // Wait out the matcher pipeline so the last accept lands
        DRAIN:
        begin
          if (drain_cnt == DRAIN_W'(MATCHER_LAT - 1))
          begin
            state <= FINAL;
          end
          else
          begin
            drain_cnt <= drain_cnt + DRAIN_W'(1);
          end
        end
        FINAL:
        begin
          state <= IDLE;
        end
        default:
        begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Packet fields held for the whole packet
  always_ff @(posedge clk)
  begin
    if (state == IDLE && pkt_start)
    begin
      stream_idx   <= stream_id;
      new_stream_q <= new_stream;
      enable_q     <= enable;
    end
  end

  assign ready    = (state == IDLE);
  assign ld       = (state == LOAD);
  // Fired flag restarts with each context load
  assign clr      = ld;
  assign scanning = (state == SCAN);
  // Enabled packets count and save, others drop both
  assign commit   = (state == FINAL) && enable_q;
  assign sv       = commit;
  assign discard  = (state == FINAL) && !enable_q;

endmodule

//--- sig_scan.f
sig_scan_pkg.sv
dfa_matcher.sv
stream_context_ram.sv
scan_control_fsm.sv
match_counter.sv
sig_scan_top.sv
sig_scan_checker.sv
sig_scan_tb.sv

//--- sig_scan_checker.sv
module sig_scan_checker (
  input logic clk,
  input logic rst_n,
  input logic pkt_start,
  input logic ready,
  input logic eop,
  input logic scanning,
  input logic ld,
  input logic ctx_vld,
  input logic sv,
  input logic commit,
  input logic discard
);

  timeunit 1ns;
  timeprecision 1ps;

  import sig_scan_pkg::*;

  // Open from a context load until that packet is finalized
  logic pkt_open;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      pkt_open <= 1'b0;
    end
    else if (ld)
    begin
      pkt_open <= 1'b1;
    end
    else if (commit || discard)
    begin
      pkt_open <= 1'b0;
    end
  end

  // Save and count go out together, once per loaded packet
  sv_with_commit: assert property (@(posedge clk) disable iff (!rst_n)
    (sv || commit) |-> (sv && commit && pkt_open))
    else $error("sv and commit not paired with one loaded packet");

  // Context restore lands as the controller enters the scan
  ld_then_ctx: assert property (@(posedge clk) disable iff (!rst_n)
    ld |=> (ctx_vld && scanning))
    else $error("ctx_vld not aligned with scan start one cycle after ld");

  // Packets start only when the controller is idle
  start_when_ready: assert property (@(posedge clk) disable iff (!rst_n) pkt_start |-> ready)
    else $error("pkt_start while ready is low");

  // Finalize comes after the full matcher drain
  final_after_drain: assert property (@(posedge clk) disable iff (!rst_n)
    (commit || discard) |-> $past(eop && scanning, MATCHER_LAT + 1))
    else $error("finalize without a drained eop");

endmodule

bind sig_scan_top sig_scan_checker u_checker (
  .clk       (clk),
  .rst_n     (rst_n),
  .pkt_start (pkt_start),
  .ready     (ready),
  .eop       (eop),
  .scanning  (scanning),
  .ld        (ld),
  .ctx_vld   (ctx_vld),
  .sv        (sv),
  .commit    (commit),
  .discard   (discard)
);

//--- sig_scan_pkg.sv
package sig_scan_pkg;

  // Bytes of the signature matched so far, 0 up to SIG_LEN-1
  typedef logic [2:0] dfa_state_t;

  // Length of the fixed signature
  localparam int SIG_LEN = 5;

  // Signature "HTTP/" in scan order
  localparam logic [7:0] SIG_BYTES [SIG_LEN] = '{
    8'h48,
    8'h54,
    8'h54,
    8'h50,
    8'h2f
  };

  // Cycles from a character at the matcher port to its accept pulse
  // One cycle of input registers plus one cycle of DFA state register
  localparam int MATCHER_LAT = 2;

  // Packet-level controller states
  typedef enum logic [2:0] {
    IDLE  = 3'd0,
    LOAD  = 3'd1,
    SCAN  = 3'd2,
    DRAIN = 3'd3,
    FINAL = 3'd4
  } ctrl_state_t;

endpackage

//--- sig_scan_tb.sv
module sig_scan_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int STREAMS      = 64;
  localparam int COUNT_W      = 16;
  localparam int PKT_MAX      = 32;
  localparam int WAIT_TIMEOUT = 200;

  logic               clk;
  logic               rst_n;
  logic               pkt_start;
  logic [5:0]         stream_id;
  logic               new_stream;
  logic               enable;
  logic [7:0]         char_in;
  logic               char_vld;
  logic               eop;
  logic               ready;
  logic               fired;
  logic [COUNT_W-1:0] count;

  // Packet under construction and its length
  logic [7:0] pkt_buf [PKT_MAX];
  int         pkt_len;

  // Model of the scanner, one saved state per stream
  string              sig_text = "HTTP/";
  logic [2:0]         model_state [STREAMS];
  logic [COUNT_W-1:0] model_count;

  // Expectations handed from stimulus to the compare process
  logic               exp_fired_q [$];
  logic [COUNT_W-1:0] exp_count_q [$];
  int                 exp_len_q [$];
  string              exp_name_q [$];

  logic [31:0] rng;
  bit          gaps_on;
  int          sent_cnt;
  int          done_cnt;
  int          check_cnt;
  int          value_errs;
  int          timeout_errs;

  sig_scan_top #(
    .STREAMS (STREAMS),
    .COUNT_W (COUNT_W)
  ) UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .pkt_start  (pkt_start),
    .stream_id  (stream_id),
    .new_stream (new_stream),
    .enable     (enable),
    .char_in    (char_in),
    .char_vld   (char_vld),
    .eop        (eop),
    .ready      (ready),
    .fired      (fired),
    .count      (count)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Xorshift32 step, state kept in rng
  function automatic logic [31:0] rand32();
    logic [31:0] x;
    x = rng;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng = x;
    return x;
  endfunction

  // Runs the packet bytes through the signature DFA
  // Returns the hit flag, fin gets the state after the last byte
  function automatic bit ref_scan(input logic [2:0] start, input int len,
                                  output logic [2:0] fin);
    logic [2:0] s;
    bit         hit;
    s   = start;
    hit = 1'b0;
    for (int i = 0; i < len; i++)
    begin
      if (pkt_buf[i] == sig_text[s])
      begin
        if (s == 3'd4)
        begin
          hit = 1'b1;
          s   = 3'd0;
        end
        else
        begin
          s = s + 3'd1;
        end
      end
      // Any other 'H' still opens a new match
      else if (pkt_buf[i] == "H")
      begin
        s = 3'd1;
      end
      else
      begin
        s = 3'd0;
      end
    end
    fin = s;
    return hit;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    check_cnt++;
    assert (act === exp)
    else
    begin
      $display("** Error %s: expected %0h, actual %0h", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic append_text(input string s);
    for (int i = 0; i < s.len(); i++)
    begin
      pkt_buf[pkt_len] = s[i];
      pkt_len++;
    end
  endtask

  // One to four pieces: whole signature, a slice of it, or filler letters
  task automatic build_random_packet();
    int    pieces;
    int    kind;
    int    a;
    int    b;
    string filler;
    filler  = "HTPXa/H";
    pkt_len = 0;
    pieces  = 1 + int'(rand32() % 32'd4);
    for (int p = 0; p < pieces; p++)
    begin
      kind = int'(rand32() % 32'd3);
      if (kind == 0)
      begin
        append_text(sig_text);
      end
      else if (kind == 1)
      begin
        a = int'(rand32() % 32'd5);
        b = a + int'(rand32() % 32'(5 - a));
        append_text(sig_text.substr(a, b));
      end
      else
      begin
        a = 1 + int'(rand32() % 32'd3);
        for (int i = 0; i < a; i++)
        begin
          pkt_buf[pkt_len] = filler[int'(rand32() % 32'd7)];
          pkt_len++;
        end
      end
    end
  endtask

  // Drives one packet from pkt_buf, always entered on a falling edge
  task automatic send_packet(input int sid, input bit newst, input bit en, input string name);
    int         waited;
    logic [2:0] fin;
    bit         hit;
    waited = 0;
    while (!ready && waited < WAIT_TIMEOUT)
    begin
      @(negedge clk);
      waited++;
    end
    if (!ready)
    begin
      $display("Timeout: ready stayed low before packet %s", name);
      timeout_errs++;
    end
    // Disabled packets keep neither the state nor the hit
    hit = ref_scan(newst ? 3'd0 : model_state[sid], pkt_len, fin);
    if (en)
    begin
      model_state[sid] = fin;
      if (hit)
      begin
        model_count = model_count + COUNT_W'(1);
      end
    end
    pkt_start  = 1'b1;
    stream_id  = 6'(sid);
    new_stream = newst;
    enable     = en;
    @(negedge clk);
    pkt_start = 1'b0;
    @(negedge clk);
    for (int i = 0; i < pkt_len; i++)
    begin
      if (gaps_on && (rand32() & 32'd3) == 32'd0)
      begin
        char_vld = 1'b0;
        @(negedge clk);
      end
      char_in  = pkt_buf[i];
      char_vld = 1'b1;
      @(negedge clk);
    end
    char_vld = 1'b0;
    eop      = 1'b1;
    exp_fired_q.push_back(hit && en);
    exp_count_q.push_back(model_count);
    exp_len_q.push_back(pkt_len);
    exp_name_q.push_back(name);
    sent_cnt++;
    @(negedge clk);
    eop    = 1'b0;
    waited = 0;
    while (done_cnt < sent_cnt && waited < WAIT_TIMEOUT)
    begin
      @(negedge clk);
      waited++;
    end
    if (done_cnt < sent_cnt)
    begin
      $display("Timeout: packet %s was never checked", name);
      timeout_errs++;
    end
  endtask

  task automatic send_text(input int sid, input bit newst, input bit en,
                           input string text, input string name);
    pkt_len = 0;
    append_text(text);
    send_packet(sid, newst, en, name);
  endtask

  task automatic finish_run();
    $display("Checks: %0d  value errors: %0d  timeouts: %0d",
             check_cnt, value_errs, timeout_errs);
    if (value_errs == 0 && timeout_errs == 0)
    begin
      $display("Testbench passed");
    end
    else
    begin
      $display("Testbench failed");
    end
    $finish;
  endtask

  // Compare process, checks each packet once ready is back
  initial
  begin
    logic               e_fired;
    logic [COUNT_W-1:0] e_count;
    int                 limit;
    int                 waited;
    string              name;
    forever
    begin
      @(negedge clk);
      if (exp_fired_q.size() > 0)
      begin
        e_fired = exp_fired_q.pop_front();
        e_count = exp_count_q.pop_front();
        limit   = exp_len_q.pop_front() + 10;
        name    = exp_name_q.pop_front();
        waited  = 0;
        while (!ready && waited < limit)
        begin
          @(negedge clk);
          waited++;
        end
        if (!ready)
        begin
          $display("Timeout: ready did not return after packet %s", name);
          timeout_errs++;
        end
        else
        begin
          check_value({name, " fired"}, 32'(e_fired), 32'(fired));
          check_value({name, " count"}, 32'(e_count), 32'(count));
        end
        done_cnt++;
      end
    end
  end

  initial
  begin
    rst_n      = 1'b0;
    pkt_start  = 1'b0;
    stream_id  = '0;
    new_stream = 1'b0;
    enable     = 1'b0;
    char_in    = '0;
    char_vld   = 1'b0;
    eop        = 1'b0;
    rng          = 32'h9468_d3db;
    gaps_on      = 1'b0;
    sent_cnt     = 0;
    done_cnt     = 0;
    check_cnt    = 0;
    value_errs   = 0;
    timeout_errs = 0;
    model_count  = '0;
    foreach (model_state[i])
    begin
      model_state[i] = 3'd0;
    end
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    // Idle state straight out of reset
    check_value("reset count", 32'd0, 32'(count));
    check_value("reset fired", 32'd0, 32'(fired));
    check_value("reset ready", 32'd1, 32'(ready));
    // Two signatures in one packet still count once
    send_text(1, 1'b1, 1'b1, "xxHTTP/yyHTTP/zz", "double_sig");
    // Split across packets, then the same split broken by new_stream
    send_text(2, 1'b1, 1'b1, "abHTT", "split_a");
    send_text(2, 1'b0, 1'b1, "P/cd", "split_b");
    send_text(3, 1'b1, 1'b1, "abHTT", "split_new_a");
    send_text(3, 1'b1, 1'b1, "P/cd", "split_new_b");
    // Another stream must not finish stream 4's prefix
    send_text(4, 1'b1, 1'b1, "xHTT", "inter_a");
    send_text(5, 1'b1, 1'b1, "P/", "inter_other");
    send_text(4, 1'b0, 1'b1, "P/", "inter_b");
    // Disabled packet drops its hit and its state
    send_text(6, 1'b1, 1'b1, "HTTP", "dis_prefix");
    send_text(6, 1'b0, 1'b0, "/", "dis_drop");
    send_text(6, 1'b0, 1'b1, "/", "dis_resume");
    // Fallback on repeated 'H' and near misses
    send_text(7, 1'b1, 1'b1, "HHTTP/", "double_h");
    send_text(7, 1'b0, 1'b1, "HTTX/", "near_miss");
    send_text(7, 1'b0, 1'b1, "HTTPX", "near_miss_tail");
    // Random traffic over a few streams with byte gaps
    gaps_on = 1'b1;
    for (int n = 0; n < 80; n++)
    begin
      build_random_packet();
      send_packet(8 + int'(rand32() % 32'd8), (rand32() % 32'd8) == 32'd0,
                  (rand32() % 32'd4) != 32'd0, $sformatf("random_%0d", n));
    end
    finish_run();
  end

endmodule

//--- sig_scan_top.sv
module sig_scan_top #(
  parameter int STREAMS = 64,
  parameter int COUNT_W = 16
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       pkt_start,
  input  logic [$clog2(STREAMS)-1:0] stream_id,
  input  logic                       new_stream,
  input  logic                       enable,
  input  logic [7:0]                 char_in,
  input  logic                       char_vld,
  input  logic                       eop,
  output logic                       ready,
  output logic                       fired,
  output logic [COUNT_W-1:0]         count
);

  import sig_scan_pkg::*;

  // Controller strobes
  logic ld;
  logic sv;
  logic clr;
  logic commit;
  logic discard;
  logic scanning;

  // Latched packet fields
  logic [$clog2(STREAMS)-1:0] stream_idx;
  logic                       new_stream_q;

  // Context path between memory and matcher
  dfa_state_t ctx_state;
  logic       ctx_vld;
  dfa_state_t state_out;
  logic       accept;

  scan_control_fsm #(
    .STREAMS (STREAMS)
  ) u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .pkt_start    (pkt_start),
    .eop          (eop),
    .enable       (enable),
    .new_stream   (new_stream),
    .stream_id    (stream_id),
    .ready        (ready),
    .ld           (ld),
    .sv           (sv),
    .clr          (clr),
    .commit       (commit),
    .discard      (discard),
    .scanning     (scanning),
    .stream_idx   (stream_idx),
    .new_stream_q (new_stream_q)
  );

  stream_context_ram #(
    .STREAMS (STREAMS)
  ) u_ctx (
    .clk        (clk),
    .rst_n      (rst_n),
    .ld         (ld),
    .sv         (sv),
    .new_stream (new_stream_q),
    .stream_idx (stream_idx),
    .state_wr   (state_out),
    .ctx_state  (ctx_state),
    .ctx_vld    (ctx_vld)
  );

  dfa_matcher u_dfa (
    .clk       (clk),
    .rst_n     (rst_n),
    .char_in   (char_in),
    .char_vld  (char_vld),
    .scanning  (scanning),
    .ctx_state (ctx_state),
    .ctx_vld   (ctx_vld),
    .state_out (state_out),
    .accept    (accept)
  );

  match_counter #(
    .COUNT_W (COUNT_W)
  ) u_cnt (
    .clk     (clk),
    .rst_n   (rst_n),
    .accept  (accept),
    .clr     (clr),
    .commit  (commit),
    .discard (discard),
    .fired   (fired),
    .count   (count)
  );

endmodule

//--- stream_context_ram.sv
module stream_context_ram #(
  parameter int STREAMS = 64
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       ld,
  input  logic                       sv,
  input  logic                       new_stream,
  input  logic [$clog2(STREAMS)-1:0] stream_idx,
  input  sig_scan_pkg::dfa_state_t   state_wr,
  output sig_scan_pkg::dfa_state_t   ctx_state,
  output logic                       ctx_vld
);

  import sig_scan_pkg::*;

  // Saved DFA state per stream
  dfa_state_t mem [STREAMS];

  // Marks streams written since reset
  // An unmarked entry reads back as the start state
  logic [STREAMS-1:0] saved;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      saved   <= '0;
      ctx_vld <= 1'b0;
    end
    else
    begin
      // Restore strobe trails ld by one cycle
      ctx_vld <= ld;
      if (sv)
      begin
        saved[stream_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (sv)
    begin
      mem[stream_idx] <= state_wr;
    end
    // A new stream always restarts from zero
    if (ld)
    begin
      ctx_state <= (new_stream || !saved[stream_idx]) ? '0 : mem[stream_idx];
    end
  end

endmodule
